// File: tlb_array.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_cmd_decode.sv
verilog/tlb_slot.sv
verilog/tlb_lookup.sv
verilog/tlb_array.sv
test/tlb_array_assertions.sv
test/tlb_array_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tlb_array testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tlb_array_tb -f tlb_array.f \
  -o tlb_array_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tlb_array_sim > sim.log 2>&1 || {
  cat sim.log
  echo "simulation stopped abnormally"
  exit 1
}
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: test/tlb_array_tb.sv
`include "tlb_config.svh"

module tlb_array_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `TLB_ENTRIES;
  localparam int HI_LSB = `TLB_VPPN_W - `TLB_VPPN_HI_W;
  localparam int RESET_OPS = 32;
  localparam int WRRD_OPS = 60;
  localparam int FILL_OPS = 40;
  localparam int SRCH_OPS = 60;
  localparam int INV_SRCH = 16;
  localparam int STALL_OPS = 300;
  // each invtlb round is a full rewrite, setup and strobe, a full readout and searches
  localparam int TEST_CYCLES = RESET_OPS + 3 * WRRD_OPS + 2 * FILL_OPS + 2 * SRCH_OPS + 8
                             + 8 * (2 * N + 2 + INV_SRCH) + 2 * STALL_OPS;

  localparam tlb_pkg::tlb_op_t OP_NONE = 5'b00000;
  localparam tlb_pkg::tlb_op_t OP_FILL = 5'b10000;
  localparam tlb_pkg::tlb_op_t OP_WR   = 5'b01000;
  localparam tlb_pkg::tlb_op_t OP_INV  = 5'b00100;
  localparam tlb_pkg::tlb_op_t OP_SRCH = 5'b00010;
  localparam tlb_pkg::tlb_op_t OP_RD   = 5'b00001;

  logic                 clk;
  logic                 rst_n;
  tlb_pkg::tlb_op_t     op;
  logic                 stall;
  tlb_pkg::tlb_idx_t    w_index;
  tlb_pkg::tlb_entry_t  w_entry;
  tlb_pkg::tlb_inv_op_e inv_op;
  tlb_pkg::tlb_vppn_t   inv_vppn;
  tlb_pkg::tlb_asid_t   inv_asid;
  tlb_pkg::tlb_vppn_t   srch_vppn;
  tlb_pkg::tlb_asid_t   srch_asid;
  logic                 srch_hit;
  tlb_pkg::tlb_idx_t    srch_idx;
  tlb_pkg::tlb_entry_t  rd_entry;

  // reference model
  tlb_pkg::tlb_entry_t  m_entry [N];
  logic                 m_addr_q [N];
  logic                 m_asid_q [N];
  tlb_pkg::tlb_idx_t    m_fill_cnt;
  tlb_pkg::tlb_idx_t    last_fill;
  logic                 exp_hit;
  tlb_pkg::tlb_idx_t    exp_idx;
  tlb_pkg::tlb_entry_t  exp_rd;

  string       cur_test;
  int          chk_cnt;
  int          err_cnt;
  int          test_cnt;
  int          test_chk0;
  int          test_err0;

  tlb_array i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (op),
    .stall_i     (stall),
    .w_index_i   (w_index),
    .w_entry_i   (w_entry),
    .inv_op_i    (inv_op),
    .inv_vppn_i  (inv_vppn),
    .inv_asid_i  (inv_asid),
    .srch_vppn_i (srch_vppn),
    .srch_asid_i (srch_asid),
    .srch_hit_o  (srch_hit),
    .srch_idx_o  (srch_idx),
    .rd_entry_o  (rd_entry)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TEST_CYCLES + 10 + 200) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + 210);
    $display("Errors found");
    $finish;
  end

  function automatic int unsigned pick(input int unsigned n);
    return $urandom % n;
  endfunction

  // small key pools so that hits and invalidates happen; first two share the upper vppn
  function automatic tlb_pkg::tlb_vppn_t pool_vppn(input int unsigned k);
    case (k)
      0: return 19'h12345;
      1: return 19'h123f0;
      2: return 19'h40010;
      default: return 19'h7ffff;
    endcase
  endfunction

  function automatic tlb_pkg::tlb_asid_t pool_asid(input int unsigned k);
    case (k)
      0: return 10'h001;
      1: return 10'h002;
      2: return 10'h155;
      default: return 10'h3ff;
    endcase
  endfunction

  function automatic tlb_pkg::tlb_entry_t rand_entry(input int unsigned invalid_pct);
    tlb_pkg::tlb_entry_t ent;
    ent.key.vppn = pool_vppn(pick(4));
    ent.key.ps = (pick(4) == 0) ? tlb_pkg::tlb_ps_t'(`TLB_PS_HUGE) : tlb_pkg::tlb_ps_t'(12);
    ent.key.g = (pick(5) == 0);
    ent.key.asid = pool_asid(pick(4));
    ent.key.e = (pick(100) >= invalid_pct);
    ent.value0 = tlb_pkg::tlb_value_t'(26'($urandom));
    ent.value1 = tlb_pkg::tlb_value_t'(26'($urandom));
    return ent;
  endfunction

  function automatic logic model_vppn_eq(input tlb_pkg::tlb_vppn_t a,
                                         input tlb_pkg::tlb_vppn_t b,
                                         input tlb_pkg::tlb_ps_t ps);
    logic hi;
    logic lo;
    hi = a[`TLB_VPPN_W-1:HI_LSB] == b[`TLB_VPPN_W-1:HI_LSB];
    lo = a[HI_LSB-1:0] == b[HI_LSB-1:0];
    return hi && (lo || ps == tlb_pkg::tlb_ps_t'(`TLB_PS_HUGE));
  endfunction

  function automatic logic model_inv_hit(input tlb_pkg::tlb_inv_op_e iop, input logic g,
                                         input logic asid_m, input logic addr_m);
    case (iop)
      tlb_pkg::INV_ALL0, tlb_pkg::INV_ALL1: return 1'b1;
      tlb_pkg::INV_GLOBAL: return g;
      tlb_pkg::INV_NONGLOBAL: return !g;
      tlb_pkg::INV_ASID: return !g && asid_m;
      tlb_pkg::INV_ASID_VA: return !g && asid_m && addr_m;
      tlb_pkg::INV_GLOBAL_OR_ASID_VA: return (g || asid_m) && addr_m;
      default: return 1'b0;
    endcase
  endfunction

  // one rising edge of the model with every decision taken on the state before the edge
  task automatic model_step();
    logic                hit;
    tlb_pkg::tlb_idx_t   hidx;
    tlb_pkg::tlb_entry_t rd;
    logic                inv_h;
    if (!stall) begin
      hit = 1'b0;
      hidx = '0;
      for (int i = 0; i < N; i++) begin
        if (m_entry[i].key.e && model_vppn_eq(m_entry[i].key.vppn, srch_vppn, m_entry[i].key.ps)
            && (m_entry[i].key.asid == srch_asid || m_entry[i].key.g)) begin
          hit = 1'b1;
          hidx = tlb_pkg::tlb_idx_t'(i);
        end
      end
      rd = m_entry[w_index].key.e ? m_entry[w_index] : '0;
      for (int i = 0; i < N; i++) begin
        inv_h = op.inv && model_inv_hit(inv_op, m_entry[i].key.g, m_asid_q[i], m_addr_q[i]);
        m_addr_q[i] = model_vppn_eq(m_entry[i].key.vppn, inv_vppn, m_entry[i].key.ps);
        m_asid_q[i] = m_entry[i].key.asid == inv_asid;
        if ((op.fill && i == int'(m_fill_cnt)) || (op.wr && i == int'(w_index))) begin
          m_entry[i] = w_entry;
        end else if (inv_h) begin
          m_entry[i].key.e = 1'b0;
        end
      end
      if (op.srch) begin
        exp_hit = hit;
        exp_idx = hidx;
      end
      if (op.rd) begin
        exp_rd = rd;
      end
      if (op.fill) begin
        last_fill = m_fill_cnt;
      end
    end
    m_fill_cnt = m_fill_cnt + tlb_pkg::tlb_idx_t'(1);
  endtask

  task automatic check_entry(input string what, input tlb_pkg::tlb_entry_t exp,
                             input tlb_pkg::tlb_entry_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_idx(input string what, input tlb_pkg::tlb_idx_t exp,
                           input tlb_pkg::tlb_idx_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s %s: expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic clock_cycle();
    @(posedge clk);
    model_step();
    #2;
    check_bit("srch_hit", exp_hit, srch_hit);
    check_idx("srch_idx", exp_idx, srch_idx);
    check_entry("rd_entry", exp_rd, rd_entry);
  endtask

  task automatic drive(input tlb_pkg::tlb_op_t o, input logic st);
    op = o;
    stall = st;
    clock_cycle();
  endtask

  // operands go out one cycle ahead of the strobe
  task automatic invalidate(input tlb_pkg::tlb_inv_op_e iop, input tlb_pkg::tlb_vppn_t vppn,
                            input tlb_pkg::tlb_asid_t asid);
    inv_op = iop;
    inv_vppn = vppn;
    inv_asid = asid;
    drive(OP_NONE, 1'b0);
    drive(OP_INV, 1'b0);
  endtask

  task automatic set_search_key();
    srch_vppn = (pick(8) == 0) ? tlb_pkg::tlb_vppn_t'(19'($urandom)) : pool_vppn(pick(4));
    srch_asid = pool_asid(pick(4));
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %s done: %0d checks, %0d mismatches", cur_test,
             chk_cnt - test_chk0, err_cnt - test_err0);
  endtask

  initial begin
    int unsigned sel;
    void'($urandom(24));
    chk_cnt = 0;
    err_cnt = 0;
    test_cnt = 0;
    rst_n = 1'b0;
    op = OP_NONE;
    stall = 1'b0;
    w_index = '0;
    w_entry = '0;
    inv_op = tlb_pkg::INV_ALL0;
    inv_vppn = '0;
    inv_asid = '0;
    srch_vppn = '0;
    srch_asid = '0;
    m_fill_cnt = '0;
    last_fill = '0;
    exp_hit = 1'b0;
    exp_idx = '0;
    exp_rd = '0;
    for (int i = 0; i < N; i++) begin
      m_entry[i] = '0;
      m_addr_q[i] = 1'b0;
      m_asid_q[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    begin_test("reset_state");
    for (int k = 0; k < RESET_OPS; k++) begin
      w_index = tlb_pkg::tlb_idx_t'(pick(N));
      set_search_key();
      drive((k % 2 == 0) ? OP_RD : OP_SRCH, 1'b0);
    end
    end_test();

    begin_test("wr_rd");
    for (int k = 0; k < WRRD_OPS; k++) begin
      w_index = tlb_pkg::tlb_idx_t'(pick(N));
      w_entry = rand_entry(15);
      drive(OP_WR, 1'b0);
      drive(OP_RD, 1'b0);
      if (k % 4 == 3) begin
        w_index = tlb_pkg::tlb_idx_t'(pick(N));
        drive(OP_RD, 1'b0);
      end
    end
    end_test();

    begin_test("fill");
    for (int k = 0; k < FILL_OPS; k++) begin
      w_entry = rand_entry(10);
      drive(OP_FILL, 1'b0);
      w_index = last_fill;
      drive(OP_RD, 1'b0);
    end
    end_test();

    begin_test("search");
    invalidate(tlb_pkg::INV_ALL0, '0, '0);
    w_entry = rand_entry(0);
    w_entry.key.vppn = 19'h40010;
    w_entry.key.ps = tlb_pkg::tlb_ps_t'(12);
    w_entry.key.g = 1'b0;
    w_index = tlb_pkg::tlb_idx_t'(3);
    drive(OP_WR, 1'b0);
    w_index = tlb_pkg::tlb_idx_t'(20);
    drive(OP_WR, 1'b0);
    srch_vppn = w_entry.key.vppn;
    srch_asid = w_entry.key.asid;
    drive(OP_SRCH, 1'b0);
    check_idx("highest index", tlb_pkg::tlb_idx_t'(20), srch_idx);
    // huge page matches on the upper vppn bits alone
    w_entry.key.vppn = 19'h12345;
    w_entry.key.ps = tlb_pkg::tlb_ps_t'(`TLB_PS_HUGE);
    w_index = tlb_pkg::tlb_idx_t'(25);
    drive(OP_WR, 1'b0);
    srch_vppn = 19'h123f0;
    drive(OP_SRCH, 1'b0);
    check_bit("huge page hit", 1'b1, srch_hit);
    check_idx("huge page index", tlb_pkg::tlb_idx_t'(25), srch_idx);
    for (int k = 0; k < SRCH_OPS; k++) begin
      w_index = tlb_pkg::tlb_idx_t'(pick(N));
      w_entry = rand_entry(10);
      drive(OP_WR, 1'b0);
      set_search_key();
      drive(OP_SRCH, 1'b0);
    end
    end_test();

    begin_test("invtlb");
    for (int r = 0; r < 8; r++) begin
      for (int i = 0; i < N; i++) begin
        w_index = tlb_pkg::tlb_idx_t'(i);
        w_entry = rand_entry(5);
        drive(OP_WR, 1'b0);
      end
      // round 7 uses an op code outside the table
      invalidate(tlb_pkg::tlb_inv_op_e'((r < 7) ? 5'(r) : 5'd9),
                 pool_vppn(pick(4)), pool_asid(pick(4)));
      for (int i = 0; i < N; i++) begin
        w_index = tlb_pkg::tlb_idx_t'(i);
        drive(OP_RD, 1'b0);
      end
      for (int k = 0; k < INV_SRCH; k++) begin
        set_search_key();
        drive(OP_SRCH, 1'b0);
      end
    end
    end_test();

    begin_test("stall");
    for (int k = 0; k < STALL_OPS; k++) begin
      sel = pick(100);
      w_index = tlb_pkg::tlb_idx_t'(pick(N));
      w_entry = rand_entry(10);
      set_search_key();
      if (sel < 10) begin
        invalidate(tlb_pkg::tlb_inv_op_e'(5'(pick(8))), pool_vppn(pick(4)), pool_asid(pick(4)));
      end else begin
        drive((sel < 30) ? OP_FILL : (sel < 55) ? OP_WR : (sel < 75) ? OP_SRCH :
              (sel < 95) ? OP_RD : OP_NONE, pick(10) == 0);
      end
    end
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: test/tlb_array_assertions.sv
`include "tlb_config.svh"

module tlb_array_assertions (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  tlb_pkg::tlb_op_t                       op_i,
  input  logic                                   stall_i,
  input  tlb_pkg::tlb_mask_t                     we_mask_i,
  input  tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries_i,
  input  logic                                   srch_hit_i,
  input  tlb_pkg::tlb_idx_t                      srch_idx_i,
  input  tlb_pkg::tlb_entry_t                    rd_entry_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [4:0] op_bits;

  assign op_bits = op_i;

  op_at_most_one: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(op_bits))
    else $error("more than one op strobe in a cycle");

  // no slot takes a write or an invalidate at a stalled edge
  entries_hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> $stable(entries_i))
    else $error("entry array changed across a stalled edge");

  we_at_most_one: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(we_mask_i))
    else $error("more than one slot write enable");

  // registered results must not move across a stalled edge
  outputs_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> $stable(srch_hit_i) && $stable(srch_idx_i) && $stable(rd_entry_i))
    else $error("search or read output changed after a stalled cycle");

endmodule

bind tlb_array tlb_array_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .op_i       (op_i),
  .stall_i    (stall_i),
  .we_mask_i  (we_mask),
  .entries_i  (entries),
  .srch_hit_i (srch_hit_o),
  .srch_idx_i (srch_idx_o),
  .rd_entry_i (rd_entry_o)
);

// File: verilog/tlb_array.sv
`include "tlb_config.svh"

module tlb_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tlb_pkg::tlb_op_t      op_i,
  input  logic                  stall_i,
  input  tlb_pkg::tlb_idx_t     w_index_i,
  input  tlb_pkg::tlb_entry_t   w_entry_i,
  input  tlb_pkg::tlb_inv_op_e  inv_op_i,
  input  tlb_pkg::tlb_vppn_t    inv_vppn_i,
  input  tlb_pkg::tlb_asid_t    inv_asid_i,
  input  tlb_pkg::tlb_vppn_t    srch_vppn_i,
  input  tlb_pkg::tlb_asid_t    srch_asid_i,
  output logic                  srch_hit_o,
  output tlb_pkg::tlb_idx_t     srch_idx_o,
  output tlb_pkg::tlb_entry_t   rd_entry_o
);

  tlb_pkg::tlb_mask_t                     we_mask;
  tlb_pkg::tlb_inv_cmd_t                  inv_cmd;
  tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries;
  tlb_pkg::tlb_mask_t                     hit_mask;

  tlb_cmd_decode u_cmd_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_i      (op_i),
    .stall_i   (stall_i),
    .w_index_i (w_index_i),
    .inv_op_i  (inv_op_i),
    .we_mask_o (we_mask),
    .inv_cmd_o (inv_cmd)
  );

  // one slot per entry sharing the broadcast operands
  for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_slot
    tlb_slot u_slot (
      .clk          (clk),
      .rst_n        (rst_n),
      .stall_i      (stall_i),
      .we_i         (we_mask[i]),
      .w_entry_i    (w_entry_i),
      .inv_cmd_i    (inv_cmd),
      .inv_vppn_i   (inv_vppn_i),
      .inv_asid_i   (inv_asid_i),
      .srch_vppn_i  (srch_vppn_i),
      .srch_asid_i  (srch_asid_i),
      .entry_o      (entries[i]),
      .srch_match_o (hit_mask[i])
    );
  end

  tlb_lookup u_lookup (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_i       (op_i),
    .stall_i    (stall_i),
    .w_index_i  (w_index_i),
    .hit_mask_i (hit_mask),
    .entries_i  (entries),
    .srch_hit_o (srch_hit_o),
    .srch_idx_o (srch_idx_o),
    .rd_entry_o (rd_entry_o)
  );

endmodule

// File: verilog/tlb_lookup.sv
`include "tlb_config.svh"

module tlb_lookup (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  tlb_pkg::tlb_op_t                          op_i,
  input  logic                                      stall_i,
  input  tlb_pkg::tlb_idx_t                         w_index_i,
  input  tlb_pkg::tlb_mask_t                        hit_mask_i,
  input  tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0]    entries_i,
  output logic                                      srch_hit_o,
  output tlb_pkg::tlb_idx_t                         srch_idx_o,
  output tlb_pkg::tlb_entry_t                       rd_entry_o
);

  logic                srch_hit;
  tlb_pkg::tlb_idx_t   srch_idx;
  tlb_pkg::tlb_entry_t rd_entry;
  logic                srch_hit_q;
  tlb_pkg::tlb_idx_t   srch_idx_q;
  tlb_pkg::tlb_entry_t rd_entry_q;

  // later index overrides so the highest hit wins
  always_comb begin
    srch_hit = 1'b0;
    srch_idx = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (hit_mask_i[i]) begin
        srch_hit = 1'b1;
        srch_idx = tlb_pkg::tlb_idx_t'(i);
      end
    end
  end

  // invalid entries read back as zeros
  always_comb begin
    rd_entry = entries_i[w_index_i];
    if (!rd_entry.key.e) begin
      rd_entry = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      srch_hit_q <= 1'b0;
      srch_idx_q <= '0;
    end else if (!stall_i && op_i.srch) begin
      srch_hit_q <= srch_hit;
      srch_idx_q <= srch_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_entry_q <= '0;
    end else if (!stall_i && op_i.rd) begin
      rd_entry_q <= rd_entry;
    end
  end

  assign srch_hit_o = srch_hit_q;
  assign srch_idx_o = srch_idx_q;
  assign rd_entry_o = rd_entry_q;

endmodule

// File: verilog/tlb_slot.sv
`include "tlb_config.svh"

module tlb_slot (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall_i,
  input  logic                   we_i,
  input  tlb_pkg::tlb_entry_t    w_entry_i,
  input  tlb_pkg::tlb_inv_cmd_t  inv_cmd_i,
  input  tlb_pkg::tlb_vppn_t     inv_vppn_i,
  input  tlb_pkg::tlb_asid_t     inv_asid_i,
  input  tlb_pkg::tlb_vppn_t     srch_vppn_i,
  input  tlb_pkg::tlb_asid_t     srch_asid_i,
  output tlb_pkg::tlb_entry_t    entry_o,
  output logic                   srch_match_o
);

  localparam int VPPN_LO_W = `TLB_VPPN_W - `TLB_VPPN_HI_W;

  tlb_pkg::tlb_entry_t entry_q;
  logic                inv_addr_match_q;
  logic                inv_asid_match_q;
  logic                inv_hit;

  // huge pages ignore the low vppn part
  function automatic logic vppn_match(
    input tlb_pkg::tlb_vppn_t ent_vppn,
    input tlb_pkg::tlb_vppn_t key_vppn,
    input tlb_pkg::tlb_ps_t   ps
  );
    logic hi_eq;
    logic lo_eq;
    hi_eq = ent_vppn[`TLB_VPPN_W-1:VPPN_LO_W] == key_vppn[`TLB_VPPN_W-1:VPPN_LO_W];
    lo_eq = ent_vppn[VPPN_LO_W-1:0] == key_vppn[VPPN_LO_W-1:0];
    return hi_eq && (lo_eq || ps == tlb_pkg::tlb_ps_t'(`TLB_PS_HUGE));
  endfunction

  assign srch_match_o = entry_q.key.e &&
                        vppn_match(entry_q.key.vppn, srch_vppn_i, entry_q.key.ps) &&
                        (entry_q.key.asid == srch_asid_i || entry_q.key.g);

  // m1 stage of invtlb keeps compare results for the strobe cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inv_addr_match_q <= 1'b0;
      inv_asid_match_q <= 1'b0;
    end else if (!stall_i) begin
      inv_addr_match_q <= vppn_match(entry_q.key.vppn, inv_vppn_i, entry_q.key.ps);
      inv_asid_match_q <= entry_q.key.asid == inv_asid_i;
    end
  end

  // invalidate op table ignores the valid bit
  always_comb begin
    inv_hit = 1'b0;
    case (inv_cmd_i.op)
      tlb_pkg::INV_ALL0,
      tlb_pkg::INV_ALL1: begin
        inv_hit = 1'b1;
      end
      tlb_pkg::INV_GLOBAL: begin
        inv_hit = entry_q.key.g;
      end
      tlb_pkg::INV_NONGLOBAL: begin
        inv_hit = !entry_q.key.g;
      end
      tlb_pkg::INV_ASID: begin
        inv_hit = !entry_q.key.g && inv_asid_match_q;
      end
      tlb_pkg::INV_ASID_VA: begin
        inv_hit = !entry_q.key.g && inv_asid_match_q && inv_addr_match_q;
      end
      tlb_pkg::INV_GLOBAL_OR_ASID_VA: begin
        inv_hit = (entry_q.key.g || inv_asid_match_q) && inv_addr_match_q;
      end
      default: begin
        inv_hit = 1'b0;
      end
    endcase
    inv_hit = inv_hit && inv_cmd_i.valid;
  end

  // a write in the same cycle takes priority over invalidate
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_q.key.e <= 1'b0;
    end else if (!stall_i) begin
      if (we_i) begin
        entry_q <= w_entry_i;
      end else if (inv_hit) begin
        entry_q.key.e <= 1'b0;
      end
    end
  end

  assign entry_o = entry_q;

endmodule

// File: verilog/tlb_cmd_decode.sv
`include "tlb_config.svh"

module tlb_cmd_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  tlb_pkg::tlb_op_t       op_i,
  input  logic                   stall_i,
  input  tlb_pkg::tlb_idx_t      w_index_i,
  input  tlb_pkg::tlb_inv_op_e   inv_op_i,
  output tlb_pkg::tlb_mask_t     we_mask_o,
  output tlb_pkg::tlb_inv_cmd_t  inv_cmd_o
);

  tlb_pkg::tlb_idx_t fill_cnt_q;

  // pseudo random fill slot that keeps running through stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt_q <= '0;
    end else begin
      fill_cnt_q <= fill_cnt_q + tlb_pkg::tlb_idx_t'(1);
    end
  end

  // one-hot write enable for the target slot
  always_comb begin
    we_mask_o = '0;
    if (!stall_i) begin
      if (op_i.fill) begin
        we_mask_o[fill_cnt_q] = 1'b1;
      end
      if (op_i.wr) begin
        we_mask_o[w_index_i] = 1'b1;
      end
    end
  end

  // broadcast to every slot where each decides on its own
  always_comb begin
    inv_cmd_o.valid = op_i.inv && !stall_i;
    inv_cmd_o.op    = inv_op_i;
  end

endmodule

// File: verilog/tlb_pkg.sv
`include "tlb_config.svh"

package tlb_pkg;

  typedef logic [`TLB_IDX_W-1:0]  tlb_idx_t;
  typedef logic [`TLB_VPPN_W-1:0] tlb_vppn_t;
  typedef logic [`TLB_ASID_W-1:0] tlb_asid_t;
  typedef logic [`TLB_PPN_W-1:0]  tlb_ppn_t;
  typedef logic [`TLB_PS_W-1:0]   tlb_ps_t;
  typedef logic [`TLB_ENTRIES-1:0] tlb_mask_t;

  typedef struct packed {
    tlb_vppn_t vppn;
    tlb_ps_t   ps;
    logic      g;
    tlb_asid_t asid;
    logic      e;
  } tlb_key_t;

  // translation of one page of the pair
  typedef struct packed {
    tlb_ppn_t   ppn;
    logic       v;
    logic       d;
    logic [1:0] plv;
    logic [1:0] mat;
  } tlb_value_t;

  typedef struct packed {
    tlb_key_t   key;
    tlb_value_t value0;
    tlb_value_t value1;
  } tlb_entry_t;

  typedef struct packed {
    logic fill;
    logic wr;
    logic inv;
    logic srch;
    logic rd;
  } tlb_op_t;

  typedef enum logic [4:0] {
    INV_ALL0              = 5'd0,
    INV_ALL1              = 5'd1,
    INV_GLOBAL            = 5'd2,
    INV_NONGLOBAL         = 5'd3,
    INV_ASID              = 5'd4,
    INV_ASID_VA           = 5'd5,
    INV_GLOBAL_OR_ASID_VA = 5'd6
  } tlb_inv_op_e;

  typedef struct packed {
    logic        valid;
    tlb_inv_op_e op;
  } tlb_inv_cmd_t;

endpackage

// File: verilog/tlb_config.svh
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

// array size and index width
`define TLB_ENTRIES 32
`define TLB_IDX_W 5

// key fields
`define TLB_VPPN_W 19
`define TLB_ASID_W 10
`define TLB_PS_W 6

// value fields
`define TLB_PPN_W 20

// huge page code compares the upper vppn bits only
`define TLB_PS_HUGE 22
`define TLB_VPPN_HI_W 9

`endif
